//--- flist.f
source/ins_decoder_pkg.sv
source/op_classifier.sv
source/mem_op_seq.sv
source/acc_op_seq.sv
source/branch_seq.sv
source/ins_decoder.sv
testbench/tb_clock_gen.sv
testbench/ins_decoder_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing -f flist.f --top-module ins_decoder_tb -Mdir "$BUILD_DIR"; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vins_decoder_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

exit 0

//--- testbench/ins_decoder_tb.sv
`timescale 1ns/1ps

module ins_decoder_tb;
    import ins_decoder_pkg::*;

    localparam int CLK_PERIOD_NS = 100;
    localparam int SETTLE_NS     = 25;  // sample point after the falling edge
    localparam int RUN_COUNT     = 80;  // upper bound on instruction runs
    localparam int WATCHDOG_NS   = (RUN_COUNT * 12 + 8) * CLK_PERIOD_NS;

    logic      clk;
    logic      rst_n;
    byte_t     instruction;
    byte_t     psw;
    byte_t     ram_data;
    byte_t     rom_data;
    phase_t    run_phase;
    micro_op_t op;
    phase_t    run_phase_init;
    int        seed;
    int        errors;
    int        checks;

    tb_clock_gen clk_gen0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ins_decoder dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .instruction    (instruction),
        .psw            (psw),
        .ram_data       (ram_data),
        .rom_data       (rom_data),
        .run_phase      (run_phase),
        .op             (op),
        .run_phase_init (run_phase_init)
    );

    function automatic byte_t rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // bank times eight plus index
    function automatic byte_t bank_addr(input byte_t psw_v, input logic [2:0] idx);
        return 8'(psw_v[4:3]) * 8'd8 + 8'(idx);
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error at %0t: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic match_op(input status_e status, input byte_t addr, input data_src_t a_src,
                            input data_src_t b_src, input alu_op_t alu);
        string where;
        where = $sformatf("(ins %h, phase %0d)", instruction, run_phase);
        check({"op.status ", where}, 32'(status), 32'(op.status));
        check({"op.addr ", where}, 32'(addr), 32'(op.addr));
        check({"op.a_src ", where}, 32'(a_src), 32'(op.a_src));
        check({"op.b_src ", where}, 32'(b_src), 32'(op.b_src));
        check({"op.alu_op ", where}, 32'(alu), 32'(op.alu_op));
    endtask

    task automatic rom_phase();
        match_op(TO_ROM_READ, 8'h00, SRC_NONE, SRC_NONE, ALU_NONE);
    endtask

    task automatic read_phase(input byte_t addr);
        match_op(TO_RAM_READ, addr, SRC_NONE, SRC_NONE, ALU_NONE);
    endtask

    task automatic write_phase(input data_src_t src, input byte_t addr);
        match_op(TO_RAM_WRITE, addr, src, SRC_NONE, ALU_NONE);
    endtask

    task automatic proc_phase(input data_src_t a_src, input data_src_t b_src, input alu_op_t alu);
        match_op(TO_PROCESS, 8'h00, a_src, b_src, alu);
    endtask

    // new opcode at phase 0 and its start count
    task automatic load_ins(input byte_t ins, input byte_t psw_v, input phase_t start);
        @(negedge clk);
        instruction = ins;
        psw         = psw_v;
        run_phase   = 4'd0;
        #(SETTLE_NS);
        check($sformatf("run_phase_init (ins %h)", ins), 32'(start), 32'(run_phase_init));
    endtask

    task automatic step(input phase_t p, input byte_t ram, input byte_t rom);
        @(negedge clk);
        run_phase = p;
        ram_data  = ram;
        rom_data  = rom;
        #(SETTLE_NS);
    endtask

    task automatic nop_and_invalid();
        load_ins(8'h00, rand_byte(), 4'd0);
        match_op(TO_NOP, 8'h00, SRC_NONE, SRC_NONE, ALU_NONE);
        load_ins(8'hA5, rand_byte(), 4'd0);  // unused opcode
        match_op(TO_GET_INS, 8'h00, SRC_NONE, SRC_NONE, ALU_NONE);
    endtask

    task automatic scratch_after_reset();
        load_ins(8'hA6, 8'h00, 4'd4);
        step(4'd1, 8'h5A, 8'h3C);
        write_phase(SRC_RAM_DATA, 8'h00);  // nothing captured yet
    endtask

    task automatic plain_moves();
        byte_t p;
        byte_t d;
        int    i;
        for (i = 0; i < 4; i++) begin
            p = rand_byte();
            d = rand_byte();
            load_ins({5'b11111, d[2:0]}, p, 4'd1);  // mov rn,a
            step(4'd1, d, ~d);
            write_phase(SRC_A, bank_addr(p, d[2:0]));
            load_ins({5'b01111, d[2:0]}, p, 4'd2);  // mov rn,#data
            step(4'd2, d, d);
            rom_phase();
            step(4'd1, ~d, d);
            write_phase(SRC_ROM_DATA, bank_addr(p, d[2:0]));
        end
        for (i = 0; i < 2; i++) begin
            p = rand_byte();
            d = rand_byte();
            load_ins({7'b1111011, i[0]}, p, 4'd2);  // mov @ri,a
            step(4'd2, ~d, ~d);
            read_phase(bank_addr(p, {2'b00, i[0]}));
            step(4'd1, d, ~d);
            write_phase(SRC_A, d);
        end
        d = rand_byte();
        load_ins(8'hF5, rand_byte(), 4'd2);  // mov direct,a
        step(4'd2, d, ~d);
        rom_phase();
        step(4'd1, ~d, d);
        write_phase(SRC_A, d);
    endtask

    // destination changes on the bus after capture
    task automatic captured_moves();
        byte_t p;
        byte_t dst;
        byte_t src;
        int    i;
        dst = rand_byte();
        src = rand_byte();
        load_ins(8'h85, rand_byte(), 4'd4);  // mov direct,direct
        step(4'd4, src, src);
        rom_phase();
        step(4'd3, src, dst);
        rom_phase();
        step(4'd2, dst, src);
        read_phase(src);
        step(4'd1, src, ~dst);
        write_phase(SRC_RAM_DATA, dst);
        dst = rand_byte();
        load_ins(8'h75, rand_byte(), 4'd3);  // mov direct,#data
        step(4'd3, src, src);
        rom_phase();
        step(4'd2, src, dst);
        rom_phase();
        step(4'd1, dst, ~dst);
        write_phase(SRC_ROM_DATA, dst);
        for (i = 0; i < 2; i++) begin
            p   = rand_byte();
            dst = rand_byte();
            src = rand_byte();
            load_ins({7'b1010011, i[0]}, p, 4'd4);  // mov @ri,direct
            step(4'd4, src, dst);
            read_phase(bank_addr(p, {2'b00, i[0]}));
            step(4'd3, dst, src);
            rom_phase();
            step(4'd2, ~dst, src);
            read_phase(src);
            step(4'd1, ~dst, ~src);
            write_phase(SRC_RAM_DATA, dst);
        end
    endtask

    task automatic acc_ops();
        byte_t   base_tab [7] = '{8'h20, 8'h30, 8'h40, 8'h50, 8'h60, 8'h90, 8'hE0};
        alu_op_t alu_tab [7] = '{ALU_ADD, ALU_ADDC, ALU_ORL, ALU_ANL, ALU_XRL, ALU_SUBB,
                                 ALU_MOV};
        byte_t   p;
        byte_t   d;
        int      k;
        for (k = 0; k < 7; k++) begin
            p = rand_byte();
            d = rand_byte();
            load_ins(base_tab[k] | 8'h08 | {5'b00000, d[2:0]}, p, 4'd2);
            step(4'd2, d, ~d);
            read_phase(bank_addr(p, d[2:0]));
            step(4'd1, d, ~d);
            proc_phase(SRC_A, SRC_RAM_DATA, alu_tab[k]);
            load_ins(base_tab[k] | 8'h06 | {7'b0000000, d[0]}, p, 4'd3);
            step(4'd3, ~d, d);
            read_phase(bank_addr(p, {2'b00, d[0]}));
            step(4'd2, d, ~d);  // pointer on ram_data
            read_phase(d);
            step(4'd1, ~d, ~d);
            proc_phase(SRC_A, SRC_RAM_DATA, alu_tab[k]);
            load_ins((k == 6) ? 8'h74 : (base_tab[k] | 8'h04), p, 4'd2);  // mov a,#data at 74h
            step(4'd2, d, d);
            rom_phase();
            step(4'd1, d, d);
            proc_phase(SRC_A, SRC_ROM_DATA, alu_tab[k]);
            load_ins(base_tab[k] | 8'h05, p, 4'd3);
            step(4'd3, d, ~d);
            rom_phase();
            step(4'd2, ~d, d);
            read_phase(d);
            step(4'd1, ~d, ~d);
            proc_phase(SRC_A, SRC_RAM_DATA, alu_tab[k]);
        end
        load_ins(8'hE4, rand_byte(), 4'd1);
        step(4'd1, 8'h00, 8'h00);
        proc_phase(SRC_A, SRC_NONE, ALU_CLR);
        load_ins(8'hF4, rand_byte(), 4'd1);
        step(4'd1, 8'h00, 8'h00);
        proc_phase(SRC_A, SRC_NONE, ALU_CPL);
    endtask

    task automatic inc_dec_ops();
        byte_t   p;
        byte_t   d;
        byte_t   ptr;
        byte_t   base;
        alu_op_t alu;
        int      b;
        for (b = 0; b < 2; b++) begin
            base = (b == 1) ? 8'h10 : 8'h00;  // bit 4 picks dec
            alu  = (b == 1) ? ALU_DEC : ALU_INC;
            p    = rand_byte();
            d    = rand_byte();
            ptr  = rand_byte();
            load_ins(base | 8'h04, p, 4'd1);
            step(4'd1, d, d);
            proc_phase(SRC_A, SRC_NONE, alu);
            load_ins(base | 8'h08 | {5'b00000, d[2:0]}, p, 4'd3);
            step(4'd3, d, d);
            read_phase(bank_addr(p, d[2:0]));
            step(4'd2, d, d);
            proc_phase(SRC_RAM_DATA, SRC_NONE, alu);
            step(4'd1, d, d);
            write_phase(SRC_RAM_DATA, bank_addr(p, d[2:0]));
            load_ins(base | 8'h05, p, 4'd4);
            step(4'd4, ptr, ~d);
            rom_phase();
            step(4'd3, ptr, d);  // address held on rom_data
            read_phase(d);
            step(4'd2, ~ptr, d);
            proc_phase(SRC_RAM_DATA, SRC_NONE, alu);
            step(4'd1, ptr, d);
            write_phase(SRC_RAM_DATA, d);
            load_ins(base | 8'h06 | {7'b0000000, ptr[0]}, p, 4'd4);
            step(4'd4, d, d);
            read_phase(bank_addr(p, {2'b00, ptr[0]}));
            step(4'd3, ptr, d);
            read_phase(ptr);
            step(4'd2, ~ptr, d);
            proc_phase(SRC_RAM_DATA, SRC_NONE, alu);
            step(4'd1, d, ~d);
            write_phase(SRC_RAM_DATA, ptr);
        end
    endtask

    task automatic jumps();
        byte_t a;
        byte_t ins;
        logic  taken;
        int    i;
        load_ins(8'h80, rand_byte(), 4'd2);  // sjmp
        step(4'd2, 8'h00, 8'h00);
        rom_phase();
        step(4'd1, 8'h00, rand_byte());
        proc_phase(SRC_PCL, SRC_ROM_DATA, ALU_ADD);
        load_ins(8'h02, rand_byte(), 4'd4);  // ljmp
        step(4'd4, 8'h00, 8'h00);
        rom_phase();
        step(4'd3, 8'h00, rand_byte());
        proc_phase(SRC_PCH, SRC_ROM_DATA, ALU_MOV);
        step(4'd2, 8'h00, 8'h00);
        rom_phase();
        step(4'd1, 8'h00, rand_byte());
        proc_phase(SRC_PCL, SRC_ROM_DATA, ALU_MOV);
        for (i = 0; i < 8; i++) begin
            load_ins({3'(i), 5'b00001}, rand_byte(), 4'd3);  // ajmp page i
            step(4'd3, 8'h00, 8'h00);
            match_op(TO_PROCESS, 8'(i), SRC_PCH, SRC_ADDR_OUT, ALU_NONE);
            step(4'd2, 8'h00, 8'h00);
            rom_phase();
            step(4'd1, 8'h00, rand_byte());
            proc_phase(SRC_PCL, SRC_ROM_DATA, ALU_MOV);
        end
        for (i = 0; i < 4; i++) begin
            ins   = i[1] ? 8'h70 : 8'h60;
            a     = i[0] ? (rand_byte() | 8'h01) : 8'h00;
            taken = i[1] ? (a != 8'h00) : (a == 8'h00);
            load_ins(ins, rand_byte(), 4'd3);
            step(4'd3, ~a, 8'h00);
            read_phase(ACC_ADDR);
            step(4'd2, a, 8'h00);
            rom_phase();
            step(4'd1, a, rand_byte());  // accumulator value on ram_data
            if (taken) begin
                proc_phase(SRC_PCL, SRC_ROM_DATA, ALU_ADD);
            end else begin
                match_op(TO_GET_INS, 8'h00, SRC_NONE, SRC_NONE, ALU_NONE);
            end
        end
    endtask

    initial begin
        instruction = 8'h00;
        psw         = 8'h00;
        ram_data    = 8'h00;
        rom_data    = 8'h00;
        run_phase   = 4'd0;
        seed        = 32'ha512b459;
        errors      = 0;
        checks      = 0;
        @(posedge rst_n);
        nop_and_invalid();
        scratch_after_reset();
        plain_moves();
        captured_moves();
        acc_ops();
        inc_dec_ops();
        jumps();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int HALF_PERIOD_NS = 50;  // 100 ns clock

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);  // release away from the capture edge
        rst_n = 1'b1;
    end

endmodule

//--- source/ins_decoder.sv
`timescale 1ns/1ps

module ins_decoder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  ins_decoder_pkg::byte_t     instruction,
    input  ins_decoder_pkg::byte_t     psw,
    input  ins_decoder_pkg::byte_t     ram_data,
    input  ins_decoder_pkg::byte_t     rom_data,
    input  ins_decoder_pkg::phase_t    run_phase,
    output ins_decoder_pkg::micro_op_t op,
    output ins_decoder_pkg::phase_t    run_phase_init
);
    import ins_decoder_pkg::*;

    decode_t   dec;
    micro_op_t mem_op;
    micro_op_t acc_op;
    micro_op_t br_op;
    phase_t    mem_init;
    phase_t    acc_init;
    phase_t    br_init;

    op_classifier u_classifier (
        .instruction (instruction),
        .psw         (psw),
        .dec         (dec)
    );

    mem_op_seq u_mem_seq (
        .clk        (clk),
        .rst_n      (rst_n),
        .dec        (dec),
        .run_phase  (run_phase),
        .ram_data   (ram_data),
        .rom_data   (rom_data),
        .op         (mem_op),
        .phase_init (mem_init)
    );

    acc_op_seq u_acc_seq (
        .dec        (dec),
        .run_phase  (run_phase),
        .ram_data   (ram_data),
        .rom_data   (rom_data),
        .op         (acc_op),
        .phase_init (acc_init)
    );

    branch_seq u_branch_seq (
        .instruction (instruction),
        .dec         (dec),
        .run_phase   (run_phase),
        .ram_data    (ram_data),
        .op          (br_op),
        .phase_init  (br_init)
    );

    always_comb begin
        case (dec.group)
            GRP_MEM: begin
                op             = mem_op;
                run_phase_init = mem_init;
            end
            GRP_ACC: begin
                op             = acc_op;
                run_phase_init = acc_init;
            end
            GRP_BRANCH: begin
                op             = br_op;
                run_phase_init = br_init;
            end
            GRP_NOP: begin
                op             = mop_status(TO_NOP);
                run_phase_init = '0;
            end
            default: begin  // unknown opcode, fetch next
                op             = mop_status(TO_GET_INS);
                run_phase_init = '0;
            end
        endcase
    end

endmodule

//--- source/branch_seq.sv
`timescale 1ns/1ps

module branch_seq (
    input  ins_decoder_pkg::byte_t     instruction,
    input  ins_decoder_pkg::decode_t   dec,
    input  ins_decoder_pkg::phase_t    run_phase,
    input  ins_decoder_pkg::byte_t     ram_data,
    output ins_decoder_pkg::micro_op_t op,
    output ins_decoder_pkg::phase_t    phase_init
);
    import ins_decoder_pkg::*;

    logic taken;

    // ram_data holds A, read in phase 3
    assign taken = (dec.form == FORM_JZ) ? (ram_data == 8'h00) : (ram_data != 8'h00);

    always_comb begin
        op         = mop_status(NOT_DONE);
        phase_init = '0;
        if (dec.group == GRP_BRANCH) begin
            case (dec.form)
                FORM_SJMP: begin
                    phase_init = 4'd2;
                    if (run_phase == 4'd2) op = mop_status(TO_ROM_READ);
                    else if (run_phase == 4'd1) op = mop_proc(SRC_PCL, SRC_ROM_DATA, ALU_ADD);
                end
                FORM_LJMP: begin
                    phase_init = 4'd4;
                    case (run_phase)
                        4'd4, 4'd2: op = mop_status(TO_ROM_READ);
                        4'd3: op = mop_proc(SRC_PCH, SRC_ROM_DATA, ALU_MOV);
                        4'd1: op = mop_proc(SRC_PCL, SRC_ROM_DATA, ALU_MOV);
                        default: ;
                    endcase
                end
                FORM_AJMP: begin
                    phase_init = 4'd3;
                    case (run_phase)
                        4'd3: begin
                            op      = mop_proc(SRC_PCH, SRC_ADDR_OUT, ALU_NONE);
                            op.addr = {5'b00000, instruction[7:5]};  // page bits
                        end
                        4'd2: op = mop_status(TO_ROM_READ);
                        4'd1: op = mop_proc(SRC_PCL, SRC_ROM_DATA, ALU_MOV);
                        default: ;
                    endcase
                end
                default: begin  // jz / jnz
                    phase_init = 4'd3;
                    case (run_phase)
                        4'd3: op = mop_read(ACC_ADDR);
                        4'd2: op = mop_status(TO_ROM_READ);
                        4'd1: op = taken ? mop_proc(SRC_PCL, SRC_ROM_DATA, ALU_ADD)
                                         : mop_status(TO_GET_INS);
                        default: ;
                    endcase
                end
            endcase
        end
    end

endmodule

//--- source/acc_op_seq.sv
`timescale 1ns/1ps

module acc_op_seq (
    input  ins_decoder_pkg::decode_t   dec,
    input  ins_decoder_pkg::phase_t    run_phase,
    input  ins_decoder_pkg::byte_t     ram_data,
    input  ins_decoder_pkg::byte_t     rom_data,
    output ins_decoder_pkg::micro_op_t op,
    output ins_decoder_pkg::phase_t    phase_init
);
    import ins_decoder_pkg::*;

    data_src_t b_src;

    assign b_src = (dec.form == FORM_IMM) ? SRC_ROM_DATA :
                   (dec.form == FORM_A)   ? SRC_NONE     : SRC_RAM_DATA;

    always_comb begin
        op         = mop_status(NOT_DONE);
        phase_init = '0;
        if (dec.group == GRP_ACC) begin
            case (dec.form)
                FORM_RN: begin
                    phase_init = 4'd2;
                    if (run_phase == 4'd2) op = mop_read(dec.reg_addr);
                end
                FORM_RI: begin
                    phase_init = 4'd3;
                    if (run_phase == 4'd3) op = mop_read(dec.reg_addr);
                    else if (run_phase == 4'd2) op = mop_read(ram_data);  // follow pointer
                end
                FORM_DIRECT: begin
                    phase_init = 4'd3;
                    if (run_phase == 4'd3) op = mop_status(TO_ROM_READ);
                    else if (run_phase == 4'd2) op = mop_read(rom_data);
                end
                FORM_IMM: begin
                    phase_init = 4'd2;
                    if (run_phase == 4'd2) op = mop_status(TO_ROM_READ);
                end
                default: phase_init = 4'd1;  // clr / cpl
            endcase
            if (run_phase == 4'd1) op = mop_proc(SRC_A, b_src, dec.alu_op);
        end
    end

endmodule

//--- source/mem_op_seq.sv
`timescale 1ns/1ps

module mem_op_seq (
    input  logic                       clk,
    input  logic                       rst_n,
    input  ins_decoder_pkg::decode_t   dec,
    input  ins_decoder_pkg::phase_t    run_phase,
    input  ins_decoder_pkg::byte_t     ram_data,
    input  ins_decoder_pkg::byte_t     rom_data,
    output ins_decoder_pkg::micro_op_t op,
    output ins_decoder_pkg::phase_t    phase_init
);
    import ins_decoder_pkg::*;

    byte_t scratch;      // held destination address
    byte_t scratch_nxt;
    logic  scratch_en;

    always_comb begin
        op          = mop_status(NOT_DONE);
        phase_init  = '0;
        scratch_en  = 1'b0;
        scratch_nxt = ram_data;
        if (dec.group == GRP_MEM) begin
            case (dec.form)
                FORM_RN: begin
                    if (dec.is_store) begin  // mov rn,a
                        phase_init = 4'd1;
                        if (run_phase == 4'd1) op = mop_write(SRC_A, dec.reg_addr);
                    end else begin
                        phase_init = 4'd3;
                        if (run_phase == 4'd3) op = mop_read(dec.reg_addr);
                        else if (run_phase == 4'd2)
                            op = mop_proc(SRC_RAM_DATA, SRC_NONE, dec.alu_op);
                        else if (run_phase == 4'd1)
                            op = mop_write(SRC_RAM_DATA, dec.reg_addr);
                    end
                end
                FORM_RI: begin
                    if (dec.is_store) begin  // mov @ri,a
                        phase_init = 4'd2;
                        if (run_phase == 4'd2) op = mop_read(dec.reg_addr);
                        else if (run_phase == 4'd1) op = mop_write(SRC_A, ram_data);
                    end else begin
                        phase_init = 4'd4;
                        case (run_phase)
                            4'd4: op = mop_read(dec.reg_addr);
                            4'd3: begin
                                scratch_en = 1'b1;  // keep the pointer for the write
                                op         = mop_read(ram_data);
                            end
                            4'd2: op = mop_proc(SRC_RAM_DATA, SRC_NONE, dec.alu_op);
                            4'd1: op = mop_write(SRC_RAM_DATA, scratch);
                            default: ;
                        endcase
                    end
                end
                FORM_DIRECT: begin
                    if (dec.is_store) begin  // mov direct,a
                        phase_init = 4'd2;
                        if (run_phase == 4'd2) op = mop_status(TO_ROM_READ);
                        else if (run_phase == 4'd1) op = mop_write(SRC_A, rom_data);
                    end else begin
                        phase_init = 4'd4;
                        case (run_phase)
                            4'd4: op = mop_status(TO_ROM_READ);
                            4'd3: op = mop_read(rom_data);
                            4'd2: op = mop_proc(SRC_RAM_DATA, SRC_NONE, dec.alu_op);
                            4'd1: op = mop_write(SRC_RAM_DATA, rom_data);
                            default: ;
                        endcase
                    end
                end
                FORM_IMM: begin  // mov rn,#data
                    phase_init = 4'd2;
                    if (run_phase == 4'd2) op = mop_status(TO_ROM_READ);
                    else if (run_phase == 4'd1) op = mop_write(SRC_ROM_DATA, dec.reg_addr);
                end
                FORM_A: begin
                    phase_init = 4'd1;
                    if (run_phase == 4'd1) op = mop_proc(SRC_A, SRC_NONE, dec.alu_op);
                end
                FORM_DIR_IMM: begin
                    phase_init = 4'd3;
                    if (run_phase == 4'd3 || run_phase == 4'd2) op = mop_status(TO_ROM_READ);
                    else if (run_phase == 4'd1) op = mop_write(SRC_ROM_DATA, scratch);
                    if (run_phase == 4'd2) begin
                        scratch_en  = 1'b1;
                        scratch_nxt = rom_data;  // destination byte
                    end
                end
                FORM_DIR_DIR, FORM_RI_DIR: begin
                    phase_init = 4'd4;
                    case (run_phase)
                        4'd4: op = (dec.form == FORM_DIR_DIR) ? mop_status(TO_ROM_READ)
                                                              : mop_read(dec.reg_addr);
                        4'd3: begin
                            scratch_en  = 1'b1;
                            scratch_nxt = (dec.form == FORM_DIR_DIR) ? rom_data : ram_data;
                            op          = mop_status(TO_ROM_READ);
                        end
                        4'd2: op = mop_read(rom_data);  // source byte
                        4'd1: op = mop_write(SRC_RAM_DATA, scratch);
                        default: ;
                    endcase
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scratch <= '0;
        end else if (scratch_en) begin
            scratch <= scratch_nxt;
        end
    end

endmodule

//--- source/op_classifier.sv
`timescale 1ns/1ps

module op_classifier (
    input  ins_decoder_pkg::byte_t   instruction,
    input  ins_decoder_pkg::byte_t   psw,
    output ins_decoder_pkg::decode_t dec
);
    import ins_decoder_pkg::*;

    logic [3:0] hi;
    logic [3:0] lo;
    logic [2:0] reg_idx;

    assign hi      = instruction[7:4];
    assign lo      = instruction[3:0];
    assign reg_idx = instruction[3] ? instruction[2:0] : {2'b00, instruction[0]}; // rn or @ri

    // operand form from the low nibble of the x4..xF rows
    function automatic form_e src_form(input logic [3:0] low);
        if (low[3])
            return FORM_RN;
        else if (low[2:1] == 2'b11)
            return FORM_RI;
        else if (low[0])
            return FORM_DIRECT;
        else
            return FORM_IMM;
    endfunction

    function automatic alu_op_t acc_alu(input logic [3:0] nib);
        case (nib)
            4'h2, 4'h3: return nib[0] ? ALU_ADDC : ALU_ADD;
            4'h4: return ALU_ORL;
            4'h5: return ALU_ANL;
            4'h6: return ALU_XRL;
            4'h9: return ALU_SUBB;
            default: return ALU_MOV;
        endcase
    endfunction

    always_comb begin
        dec.group    = GRP_INVALID;
        dec.form     = FORM_RN;
        dec.is_store = 1'b0;
        dec.alu_op   = ALU_NONE;
        dec.reg_addr = {3'b000, psw[4:3], reg_idx};
        casez (instruction)
            8'h00: dec.group = GRP_NOP;
            8'h80, 8'h02, 8'b???0_0001, 8'h60, 8'h70: begin
                dec.group = GRP_BRANCH;
                if (instruction == 8'h80) dec.form = FORM_SJMP;
                else if (instruction == 8'h02) dec.form = FORM_LJMP;
                else if (instruction == 8'h60) dec.form = FORM_JZ;
                else if (instruction == 8'h70) dec.form = FORM_JNZ;
                else dec.form = FORM_AJMP;
            end
            8'hE4, 8'hF4: begin         // clr a / cpl a
                dec.group  = GRP_ACC;
                dec.form   = FORM_A;
                dec.alu_op = hi[0] ? ALU_CPL : ALU_CLR;
            end
            8'h74: begin                // mov a,#data
                dec.group  = GRP_ACC;
                dec.form   = FORM_IMM;
                dec.alu_op = ALU_MOV;
            end
            8'b1111_1???, 8'b1111_011?, 8'hF5, 8'b0111_1???: begin
                dec.group    = GRP_MEM;
                dec.is_store = 1'b1;
                dec.form     = hi[3] ? src_form(lo) : FORM_IMM;  // source A or #data
            end
            8'h75, 8'h85, 8'b1010_011?: begin
                dec.group    = GRP_MEM;
                dec.is_store = 1'b1;
                if (hi == 4'h7) dec.form = FORM_DIR_IMM;
                else if (hi == 4'h8) dec.form = FORM_DIR_DIR;
                else dec.form = FORM_RI_DIR;
            end
            8'b000?_????: begin
                if (lo[3] | lo[2]) begin  // inc/dec
                    dec.group  = GRP_MEM;
                    dec.form   = (lo == 4'h4) ? FORM_A : src_form(lo);
                    dec.alu_op = hi[0] ? ALU_DEC : ALU_INC;
                end
            end
            8'b001?_????, 8'b010?_????, 8'b0110_????, 8'b1001_????, 8'b1110_????: begin
                if (lo[3] | lo[2]) begin
                    dec.group  = GRP_ACC;
                    dec.form   = src_form(lo);
                    dec.alu_op = acc_alu(hi);
                end
            end
            default: ;
        endcase
    end

endmodule

//--- source/ins_decoder_pkg.sv
package ins_decoder_pkg;

    typedef logic [7:0] byte_t;      // opcode, address or data byte
    typedef logic [3:0] phase_t;     // run phase and start count
    typedef logic [2:0] data_src_t;  // alu operand source
    typedef logic [3:0] alu_op_t;

    typedef enum logic [2:0] {
        TO_NOP       = 3'b000,
        TO_RAM_READ  = 3'b001,
        TO_ROM_READ  = 3'b010,
        TO_PROCESS   = 3'b011,
        TO_RAM_WRITE = 3'b100,
        TO_GET_INS   = 3'b101,
        NOT_DONE     = 3'b111
    } status_e;

    localparam data_src_t SRC_A        = 3'd0;
    localparam data_src_t SRC_RAM_DATA = 3'd1;
    localparam data_src_t SRC_ROM_DATA = 3'd2;
    localparam data_src_t SRC_ADDR_OUT = 3'd3;
    localparam data_src_t SRC_PCH      = 3'd4;
    localparam data_src_t SRC_PCL      = 3'd5;
    localparam data_src_t SRC_B        = 3'd6;
    localparam data_src_t SRC_NONE     = 3'd7;

    localparam alu_op_t ALU_NONE = 4'd0;
    localparam alu_op_t ALU_ADD  = 4'd1;
    localparam alu_op_t ALU_ADDC = 4'd2;
    localparam alu_op_t ALU_SUBB = 4'd3;
    localparam alu_op_t ALU_ANL  = 4'd4;
    localparam alu_op_t ALU_ORL  = 4'd5;
    localparam alu_op_t ALU_XRL  = 4'd6;
    localparam alu_op_t ALU_MOV  = 4'd7;
    localparam alu_op_t ALU_INC  = 4'd8;
    localparam alu_op_t ALU_DEC  = 4'd9;
    localparam alu_op_t ALU_CLR  = 4'd10;
    localparam alu_op_t ALU_CPL  = 4'd11;

    typedef enum logic [2:0] {
        GRP_NOP, GRP_MEM, GRP_ACC, GRP_BRANCH, GRP_INVALID
    } group_e;

    typedef enum logic [3:0] {
        FORM_RN, FORM_RI, FORM_DIRECT, FORM_IMM, FORM_A,
        FORM_DIR_DIR, FORM_RI_DIR, FORM_DIR_IMM,
        FORM_SJMP, FORM_LJMP, FORM_AJMP, FORM_JZ, FORM_JNZ
    } form_e;

    typedef struct packed {
        group_e  group;
        form_e   form;
        logic    is_store;  // move that writes its destination
        alu_op_t alu_op;
        byte_t   reg_addr;  // banked rn / ri address
    } decode_t;

    typedef struct packed {
        status_e   status;
        byte_t     addr;
        data_src_t a_src;
        data_src_t b_src;
        alu_op_t   alu_op;
    } micro_op_t;

    localparam byte_t ACC_ADDR = 8'hE0;

    // bare status, all other fields idle
    function automatic micro_op_t mop_status(status_e status);
        return '{status: status, addr: 8'h00, a_src: SRC_NONE, b_src: SRC_NONE,
                 alu_op: ALU_NONE};
    endfunction

    function automatic micro_op_t mop_read(byte_t addr);
        return '{status: TO_RAM_READ, addr: addr, a_src: SRC_NONE, b_src: SRC_NONE,
                 alu_op: ALU_NONE};
    endfunction

    function automatic micro_op_t mop_write(data_src_t src, byte_t addr);
        return '{status: TO_RAM_WRITE, addr: addr, a_src: src, b_src: SRC_NONE,
                 alu_op: ALU_NONE};
    endfunction

    function automatic micro_op_t mop_proc(data_src_t a_src, data_src_t b_src, alu_op_t op);
        return '{status: TO_PROCESS, addr: 8'h00, a_src: a_src, b_src: b_src, alu_op: op};
    endfunction

endpackage
